// File: conv_accel.f
+incdir+common
common/conv_pkg.sv
common/dram_pkg.sv
common/dram_beat_if.sv
hdl/conv_ctrl_fsm.sv
hdl/burst_counter.sv
conv/line_window.sv
conv/mac_array.sv
hdl/result_writer.sv
hdl/conv_top.sv
verif/conv_asserts.sv
verif/conv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the convolution testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f conv_accel.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vconv_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// File: verif/conv_tb.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tb;

  localparam int ROWS           = `CONV_IMG_ROWS;
  localparam int COLS           = `CONV_IMG_COLS;
  localparam int KD             = `CONV_KERNEL_DIM;
  localparam int LAT            = `CONV_DRAM_LATENCY;
  localparam int BLEN           = `CONV_BURST_LEN;
  localparam int OUT_COLS       = COLS - KD + 1;
  localparam int MEM_BYTES      = `CONV_IMG_BASE + ROWS * COLS;
  localparam int N_READS        = 2 + ROWS * COLS / BLEN;
  localparam int N_OUT          = (ROWS - KD + 1) * OUT_COLS;
  localparam int N_RUNS         = 3;
  localparam int TIMEOUT_CYCLES = N_RUNS * N_READS * 16 + 400;

  logic                 clk = 1'b0;
  logic                 reset_n;
  logic                 i_start;
  logic                 o_ready;
  dram_pkg::dram_cmd_e  o_input_cmd;
  dram_pkg::dram_addr_t o_input_addr;
  conv_pkg::pixel_t     i_input_dout;
  dram_pkg::dram_cmd_e  o_output_cmd;
  dram_pkg::dram_addr_t o_output_addr;
  conv_pkg::pixel_t     o_output_din;
  logic                 o_output_oe;

  conv_pkg::pixel_t     dram_mem [MEM_BYTES];
  conv_pkg::pixel_t     exp_out [N_OUT];
  dram_pkg::dram_addr_t rd_addr;
  int                   rd_age;
  int                   rd_cnt = 0;
  int                   wr_cnt = 0;
  int                   cycle_cnt;
  int                   data_errors = 0;
  int                   addr_errors = 0;
  int                   proto_errors = 0;
  int                   run_errors = 0;
  int unsigned          seed_val;

  always #20 clk = ~clk;

  conv_top conv_top_inst (.*);

  bind conv_top conv_asserts u_asserts (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_start      (i_start),
    .i_ready      (o_ready),
    .i_input_cmd  (o_input_cmd),
    .i_output_cmd (o_output_cmd),
    .i_output_oe  (o_output_oe)
  );

  function automatic dram_pkg::dram_addr_t read_addr_for(int n);
    if (n < 2) begin
      return dram_pkg::dram_addr_t'(`CONV_KERNEL_BASE + n * BLEN);
    end
    return dram_pkg::dram_addr_t'(`CONV_IMG_BASE + (n - 2) * BLEN);
  endfunction

  function automatic conv_pkg::pixel_t clamp_byte(int v);
    if (v > 127) begin
      return 8'sd127;
    end else if (v < -128) begin
      return -8'sd128;
    end
    return conv_pkg::pixel_t'(v);
  endfunction

  // Kernel byte i*4+j times pixel (r+i, c+j), raster order of window corners
  task automatic compute_expected();
    int acc;
    for (int r = 0; r <= ROWS - KD; r++) begin
      for (int c = 0; c < OUT_COLS; c++) begin
        acc = 0;
        for (int i = 0; i < KD; i++) begin
          for (int j = 0; j < KD; j++) begin
            acc += int'(dram_mem[`CONV_KERNEL_BASE + i * KD + j]) *
                   int'(dram_mem[`CONV_IMG_BASE + (r + i) * COLS + c + j]);
          end
        end
        exp_out[r * OUT_COLS + c] = clamp_byte(acc);
      end
    end
  endtask

  task automatic fill_random();
    for (int a = 0; a < MEM_BYTES; a++) begin
      // Small values keep most sums inside the byte range
      if (a < `CONV_IMG_BASE) begin
        dram_mem[a] = conv_pkg::pixel_t'(int'($urandom_range(7)) - 4);
      end else begin
        dram_mem[a] = conv_pkg::pixel_t'(int'($urandom_range(15)) - 8);
      end
    end
  endtask

  task automatic fill_constant(input conv_pkg::pixel_t kval, input conv_pkg::pixel_t pval);
    for (int a = 0; a < MEM_BYTES; a++) begin
      dram_mem[a] = (a < `CONV_IMG_BASE) ? kval : pval;
    end
  endtask

  task automatic print_counts();
    $display("error counts: data %0d, address %0d, protocol %0d, run %0d, assertion %0d",
             data_errors, addr_errors, proto_errors, run_errors,
             conv_top_inst.u_asserts.fail_cnt);
  endtask

  // One run, optionally with a stray start pulse in the middle of it
  task automatic run_once(input bit poke_start);
    compute_expected();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    if (poke_start) begin
      repeat (40) @(posedge clk);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
    end
    do @(negedge clk); while (!o_ready);
    // Last write lands with the rise of o_ready
    repeat (4) @(negedge clk);
    assert (rd_cnt == N_READS) else begin
      run_errors++;
      $display("mismatch at %0t: read count = %0d, expected %0d", $time, rd_cnt, N_READS);
    end
    assert (wr_cnt == N_OUT) else begin
      run_errors++;
      $display("mismatch at %0t: write count = %0d, expected %0d", $time, wr_cnt, N_OUT);
    end
  endtask

  // DRAM model, byte k of a burst on the pins LAT+k cycles after the READ
  initial begin
    i_input_dout = '0;
    rd_age = 0;
    rd_addr = '0;
    forever begin
      @(posedge clk);
      if (o_input_cmd == dram_pkg::READ) begin
        rd_addr      <= o_input_addr;
        rd_age       <= 1;
        i_input_dout <= '0;
      end else begin
        if (rd_age != 0 && rd_age < 255) begin
          rd_age <= rd_age + 1;
        end
        if (rd_age >= LAT - 1 && rd_age <= LAT + BLEN - 2) begin
          i_input_dout <= dram_mem[int'(rd_addr) + rd_age - (LAT - 1)];
        end else begin
          i_input_dout <= '0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (reset_n) begin
      if (i_start && o_ready) begin
        rd_cnt <= 0;
        wr_cnt <= 0;
      end
      if (o_input_cmd == dram_pkg::READ) begin
        assert (o_input_addr == read_addr_for(rd_cnt)) else begin
          addr_errors++;
          $display("mismatch at %0t: o_input_addr = %0d, expected %0d",
                   $time, o_input_addr, read_addr_for(rd_cnt));
        end
        assert (rd_age == 0 || rd_age >= LAT + BLEN) else begin
          proto_errors++;
          $display("READ issued at %0t while a burst was still arriving", $time);
        end
        rd_cnt <= rd_cnt + 1;
      end
      if (o_output_cmd == dram_pkg::WRITE) begin
        assert (wr_cnt < N_OUT) else begin
          proto_errors++;
          $display("more writes than windows at %0t", $time);
        end
        if (wr_cnt < N_OUT) begin
          assert (o_output_addr == dram_pkg::dram_addr_t'(`CONV_OUT_BASE + wr_cnt)) else begin
            addr_errors++;
            $display("mismatch at %0t: o_output_addr = %0d, expected %0d",
                     $time, o_output_addr, `CONV_OUT_BASE + wr_cnt);
          end
          assert (o_output_din == exp_out[wr_cnt]) else begin
            data_errors++;
            $display("mismatch at %0t: o_output_din = %0d, expected %0d",
                     $time, o_output_din, exp_out[wr_cnt]);
          end
        end
        wr_cnt <= wr_cnt + 1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_counts();
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    reset_n = 1'b0;
    i_start = 1'b0;
    seed_val = $urandom(32'h5970);
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    assert (o_ready) else begin
      run_errors++;
      $display("o_ready is low after reset");
    end
    fill_random();
    run_once(1'b1);
    // Saturation at both ends, each with a new kernel
    fill_constant(8'sd127, 8'sd127);
    run_once(1'b0);
    fill_constant(-8'sd128, 8'sd127);
    run_once(1'b0);
    print_counts();
    if (data_errors + addr_errors + proto_errors + run_errors +
        conv_top_inst.u_asserts.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/conv_asserts.sv
`timescale 1ns/1ps

module conv_asserts (
  input logic                clk,
  input logic                reset_n,
  input logic                i_start,
  input logic                i_ready,
  input dram_pkg::dram_cmd_e i_input_cmd,
  input dram_pkg::dram_cmd_e i_output_cmd,
  input logic                i_output_oe
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Accepted start drops ready in the next cycle
  ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
    (i_start && i_ready) |=> !i_ready)
    else begin
      fail_cnt++;
      $error("o_ready did not fall after an accepted start");
    end

  // Reads only happen inside a run
  read_in_run: assert property (@(posedge clk) disable iff (!reset_n)
    (i_input_cmd == dram_pkg::READ) |-> !i_ready)
    else begin
      fail_cnt++;
      $error("READ issued while o_ready is high");
    end

  read_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    (i_input_cmd == dram_pkg::READ) |=> (i_input_cmd != dram_pkg::READ))
    else begin
      fail_cnt++;
      $error("READ command held for more than one cycle");
    end

  oe_on_write: assert property (@(posedge clk) disable iff (!reset_n)
    i_output_oe == (i_output_cmd == dram_pkg::WRITE))
    else begin
      fail_cnt++;
      $error("o_output_oe does not match the WRITE command");
    end

endmodule

// File: hdl/conv_top.sv
`timescale 1ns/1ps

module conv_top (
  input  logic                 clk,
  input  logic                 reset_n,

  input  logic                 i_start,
  output logic                 o_ready,

  output dram_pkg::dram_cmd_e  o_input_cmd,
  output dram_pkg::dram_addr_t o_input_addr,
  input  conv_pkg::pixel_t     i_input_dout,

  output dram_pkg::dram_cmd_e  o_output_cmd,
  output dram_pkg::dram_addr_t o_output_addr,
  output conv_pkg::pixel_t     o_output_din,
  output logic                 o_output_oe
);

  logic               burst_start;
  logic               kernel_phase;
  logic               burst_done;
  logic               last_burst;
  logic               start_accepted;
  logic               win_valid;
  logic               res_valid;
  conv_pkg::window_t  window;
  conv_pkg::pixel_t   result;

  dram_beat_if beat_if ();

  // Start only counts while idle
  assign start_accepted = i_start && o_ready;

  conv_ctrl_fsm u_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_start        (i_start),
    .i_burst_done   (burst_done),
    .i_last_burst   (last_burst),
    .o_ready        (o_ready),
    .o_input_cmd    (o_input_cmd),
    .o_input_addr   (o_input_addr),
    .o_burst_start  (burst_start),
    .o_kernel_phase (kernel_phase)
  );

  burst_counter u_burst (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_burst_start  (burst_start),
    .i_kernel_phase (kernel_phase),
    .i_input_dout   (i_input_dout),
    .o_burst_done   (burst_done),
    .o_last_burst   (last_burst),
    .beat           (beat_if.source)
  );

  line_window u_window (
    .clk         (clk),
    .reset_n     (reset_n),
    .beat        (beat_if.sink),
    .o_win_valid (win_valid),
    .o_window    (window)
  );

  mac_array u_mac (
    .clk         (clk),
    .reset_n     (reset_n),
    .beat        (beat_if.sink),
    .i_win_valid (win_valid),
    .i_window    (window),
    .o_res_valid (res_valid),
    .o_result    (result)
  );

  result_writer u_writer (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_res_valid   (res_valid),
    .i_result      (result),
    .i_start       (start_accepted),
    .o_output_cmd  (o_output_cmd),
    .o_output_addr (o_output_addr),
    .o_output_din  (o_output_din),
    .o_output_oe   (o_output_oe)
  );

endmodule

// File: hdl/result_writer.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module result_writer (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 i_res_valid,
  input  conv_pkg::pixel_t     i_result,
  input  logic                 i_start,
  output dram_pkg::dram_cmd_e  o_output_cmd,
  output dram_pkg::dram_addr_t o_output_addr,
  output conv_pkg::pixel_t     o_output_din,
  output logic                 o_output_oe
);

  localparam dram_pkg::dram_addr_t OUT_ADDR = dram_pkg::dram_addr_t'(`CONV_OUT_BASE);

  dram_pkg::dram_addr_t addr_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_output_cmd <= dram_pkg::IDLE;
      o_output_oe  <= 1'b0;
      addr_cnt     <= OUT_ADDR;
    end else begin
      o_output_cmd <= i_res_valid ? dram_pkg::WRITE : dram_pkg::IDLE;
      o_output_oe  <= i_res_valid;
      // Results arrive in raster order, one byte each
      if (i_start) begin
        addr_cnt <= OUT_ADDR;
      end else if (i_res_valid) begin
        addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_res_valid) begin
      o_output_addr <= addr_cnt;
      o_output_din  <= i_result;
    end
  end

endmodule

// File: conv/mac_array.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module mac_array (
  input  logic               clk,
  input  logic               reset_n,
  dram_beat_if.sink          beat,
  input  logic               i_win_valid,
  input  conv_pkg::window_t  i_window,
  output logic               o_res_valid,
  output conv_pkg::pixel_t   o_result
);

  localparam int KD = `CONV_KERNEL_DIM;

  localparam conv_pkg::sum_t SAT_MAX = conv_pkg::sum_t'(127);
  localparam conv_pkg::sum_t SAT_MIN = conv_pkg::sum_t'(-128);

  conv_pkg::coef_t    kern    [KD][KD];
  conv_pkg::product_t prod    [KD][KD];
  conv_pkg::sum_t     row_acc [KD];
  conv_pkg::sum_t     row_sum [KD];
  conv_pkg::sum_t     total;
  logic               v1;
  logic               v2;

  // Coefficients arrive row by row
  always_ff @(posedge clk) begin
    if (beat.valid && beat.is_kernel) begin
      kern[beat.kidx / KD][beat.kidx % KD] <= beat.data;
    end
  end

  always_comb begin
    for (int i = 0; i < KD; i++) begin
      row_acc[i] = '0;
      for (int j = 0; j < KD; j++) begin
        row_acc[i] = row_acc[i] + conv_pkg::sum_t'(prod[i][j]);
      end
    end
    total = '0;
    for (int i = 0; i < KD; i++) begin
      total = total + row_sum[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      v1          <= 1'b0;
      v2          <= 1'b0;
      o_res_valid <= 1'b0;
    end else begin
      v1          <= i_win_valid;
      v2          <= v1;
      o_res_valid <= v2;
    end
  end

  always_ff @(posedge clk) begin
    // Stage 1, products
    for (int i = 0; i < KD; i++) begin
      for (int j = 0; j < KD; j++) begin
        prod[i][j] <= kern[i][j] * i_window[i][j];
      end
    end
    // Stage 2, row sums
    for (int i = 0; i < KD; i++) begin
      row_sum[i] <= row_acc[i];
    end
    // Stage 3, total clamped to a byte
    if (total > SAT_MAX) begin
      o_result <= conv_pkg::pixel_t'(SAT_MAX);
    end else if (total < SAT_MIN) begin
      o_result <= conv_pkg::pixel_t'(SAT_MIN);
    end else begin
      o_result <= conv_pkg::pixel_t'(total);
    end
  end

endmodule

// File: conv/line_window.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module line_window (
  input  logic               clk,
  input  logic               reset_n,
  dram_beat_if.sink          beat,
  output logic               o_win_valid,
  output conv_pkg::window_t  o_window
);

  localparam int KD    = `CONV_KERNEL_DIM;
  localparam int COLS  = `CONV_IMG_COLS;
  localparam int NBUF  = KD - 1;
  localparam int SEL_W = $clog2(NBUF);
  localparam int ROW_W = $clog2(`CONV_IMG_ROWS);
  localparam int COL_W = $clog2(COLS);

  // Last three image rows, wr_sel points at the oldest one
  conv_pkg::pixel_t row_buf [NBUF][COLS];
  logic [SEL_W-1:0] wr_sel;
  logic [SEL_W-1:0] rd_sel [NBUF];
  conv_pkg::pixel_t new_col [KD];
  logic             img_beat;

  assign img_beat = beat.valid && !beat.is_kernel;

  // New column, top is row r-3, bottom is the arriving pixel
  always_comb begin
    for (int k = 0; k < NBUF; k++) begin
      if (int'(wr_sel) + k >= NBUF) begin
        rd_sel[k] = SEL_W'(int'(wr_sel) + k - NBUF);
      end else begin
        rd_sel[k] = SEL_W'(int'(wr_sel) + k);
      end
      new_col[k] = row_buf[rd_sel[k]][beat.col];
    end
    new_col[KD-1] = beat.data;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_sel      <= '0;
      o_win_valid <= 1'b0;
    end else begin
      o_win_valid <= img_beat &&
                     (beat.row >= ROW_W'(KD - 1)) &&
                     (beat.col >= COL_W'(KD - 1));
      if (beat.valid) begin
        if (beat.is_kernel) begin
          wr_sel <= '0;
        end else if (beat.col == COL_W'(COLS - 1)) begin
          // Rotate buffers at the end of each image row
          if (wr_sel == SEL_W'(NBUF - 1)) begin
            wr_sel <= '0;
          end else begin
            wr_sel <= wr_sel + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (img_beat) begin
      row_buf[wr_sel][beat.col] <= beat.data;
      for (int i = 0; i < KD; i++) begin
        for (int j = 0; j < KD - 1; j++) begin
          o_window[i][j] <= o_window[i][j+1];
        end
        o_window[i][KD-1] <= new_col[i];
      end
    end
  end

endmodule

// File: hdl/burst_counter.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module burst_counter (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              i_burst_start,
  input  logic              i_kernel_phase,
  input  conv_pkg::pixel_t  i_input_dout,
  output logic              o_burst_done,
  output logic              o_last_burst,
  dram_beat_if.source       beat
);

  localparam int KD     = `CONV_KERNEL_DIM;
  localparam int LAT_W  = $clog2(`CONV_DRAM_LATENCY + 1);
  localparam int BEAT_W = $clog2(`CONV_BURST_LEN);
  localparam int KIDX_W = $clog2(KD * KD);
  localparam int ROW_W  = $clog2(`CONV_IMG_ROWS);
  localparam int COL_W  = $clog2(`CONV_IMG_COLS);

  logic              waiting;
  logic              capturing;
  logic              kernel_q;
  logic [LAT_W-1:0]  lat_cnt;
  logic [BEAT_W-1:0] beat_cnt;
  logic [KIDX_W-1:0] kidx_cnt;
  logic [ROW_W-1:0]  row_cnt;
  logic [COL_W-1:0]  col_cnt;

  assign o_burst_done = capturing && (beat_cnt == BEAT_W'(`CONV_BURST_LEN - 1));
  assign o_last_burst = capturing && !kernel_q &&
                        (row_cnt == ROW_W'(`CONV_IMG_ROWS - 1)) &&
                        (col_cnt == COL_W'(`CONV_IMG_COLS - 1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      waiting    <= 1'b0;
      capturing  <= 1'b0;
      kernel_q   <= 1'b0;
      lat_cnt    <= '0;
      beat_cnt   <= '0;
      kidx_cnt   <= '0;
      row_cnt    <= '0;
      col_cnt    <= '0;
      beat.valid <= 1'b0;
    end else begin
      beat.valid <= capturing;

      // Latency timer, first byte lands LATENCY cycles after the READ
      if (i_burst_start) begin
        waiting  <= 1'b1;
        lat_cnt  <= LAT_W'(1);
        kernel_q <= i_kernel_phase;
      end else if (waiting) begin
        if (lat_cnt == LAT_W'(`CONV_DRAM_LATENCY - 1)) begin
          waiting   <= 1'b0;
          capturing <= 1'b1;
          beat_cnt  <= '0;
        end else begin
          lat_cnt <= lat_cnt + 1'b1;
        end
      end

      if (capturing) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (o_burst_done) begin
          capturing <= 1'b0;
        end
        // Kernel beats also rewind the image position for the next run
        if (kernel_q) begin
          kidx_cnt <= kidx_cnt + 1'b1;
          row_cnt  <= '0;
          col_cnt  <= '0;
        end else begin
          kidx_cnt <= '0;
          if (col_cnt == COL_W'(`CONV_IMG_COLS - 1)) begin
            col_cnt <= '0;
            row_cnt <= row_cnt + 1'b1;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capturing) begin
      beat.data      <= i_input_dout;
      beat.is_kernel <= kernel_q;
      beat.kidx      <= kidx_cnt;
      beat.row       <= row_cnt;
      beat.col       <= col_cnt;
    end
  end

endmodule

// File: hdl/conv_ctrl_fsm.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_ctrl_fsm (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 i_start,
  input  logic                 i_burst_done,
  input  logic                 i_last_burst,
  output logic                 o_ready,
  output dram_pkg::dram_cmd_e  o_input_cmd,
  output dram_pkg::dram_addr_t o_input_addr,
  output logic                 o_burst_start,
  output logic                 o_kernel_phase
);

  localparam int DRAIN_CYCLES = 5;
  localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

  localparam dram_pkg::dram_addr_t KERNEL_ADDR = dram_pkg::dram_addr_t'(`CONV_KERNEL_BASE);
  localparam dram_pkg::dram_addr_t KERNEL_LAST =
    dram_pkg::dram_addr_t'(`CONV_KERNEL_BASE + `CONV_BURST_LEN);
  localparam dram_pkg::dram_addr_t IMG_ADDR    = dram_pkg::dram_addr_t'(`CONV_IMG_BASE);
  localparam dram_pkg::dram_addr_t BURST_STEP  = dram_pkg::dram_addr_t'(`CONV_BURST_LEN);

  typedef enum logic [1:0] {
    IDLE,
    KERNEL_READ,
    IMAGE_READ,
    DRAIN
  } state_e;

  state_e             state;
  logic [DRAIN_W-1:0] drain_cnt;

  assign o_kernel_phase = (state == KERNEL_READ);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state         <= IDLE;
      o_ready       <= 1'b1;
      o_input_cmd   <= dram_pkg::IDLE;
      o_input_addr  <= KERNEL_ADDR;
      o_burst_start <= 1'b0;
      drain_cnt     <= '0;
    end else begin
      // READ and burst start are single cycle pulses
      o_input_cmd   <= dram_pkg::IDLE;
      o_burst_start <= 1'b0;

      case (state)
        IDLE: begin
          if (i_start && o_ready) begin
            o_ready       <= 1'b0;
            state         <= KERNEL_READ;
            o_input_cmd   <= dram_pkg::READ;
            o_input_addr  <= KERNEL_ADDR;
            o_burst_start <= 1'b1;
          end
        end
        KERNEL_READ: begin
          if (i_burst_done) begin
            o_input_cmd   <= dram_pkg::READ;
            o_burst_start <= 1'b1;
            // Second kernel burst done, image follows
            if (o_input_addr == KERNEL_LAST) begin
              state        <= IMAGE_READ;
              o_input_addr <= IMG_ADDR;
            end else begin
              o_input_addr <= o_input_addr + BURST_STEP;
            end
          end
        end
        IMAGE_READ: begin
          if (i_burst_done) begin
            if (i_last_burst) begin
              state     <= DRAIN;
              drain_cnt <= '0;
            end else begin
              o_input_cmd   <= dram_pkg::READ;
              o_input_addr  <= o_input_addr + BURST_STEP;
              o_burst_start <= 1'b1;
            end
          end
        end
        DRAIN: begin
          // Let the window and MAC pipeline empty
          if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
            state   <= IDLE;
            o_ready <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: common/dram_beat_if.sv
`timescale 1ns/1ps
`include "conv_params.svh"

// One captured DRAM byte with its position in the kernel or the image
interface dram_beat_if;
  logic                                                   valid;
  logic                                                   is_kernel;
  conv_pkg::pixel_t                                       data;
  logic [$clog2(`CONV_KERNEL_DIM*`CONV_KERNEL_DIM)-1:0]   kidx;
  logic [$clog2(`CONV_IMG_ROWS)-1:0]                      row;
  logic [$clog2(`CONV_IMG_COLS)-1:0]                      col;

  modport source (output valid, is_kernel, data, kidx, row, col);
  modport sink   (input  valid, is_kernel, data, kidx, row, col);
endinterface

// File: common/dram_pkg.sv
`include "conv_params.svh"

package dram_pkg;

  // Command encoding on both DRAM ports
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    READ  = 2'b01,
    WRITE = 2'b10
  } dram_cmd_e;

  typedef logic [`CONV_ADDR_W-1:0] dram_addr_t;

endpackage

// File: common/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

  // Signed image pixel and kernel coefficient
  typedef logic signed [`CONV_PIXEL_W-1:0] pixel_t;
  typedef logic signed [`CONV_PIXEL_W-1:0] coef_t;

  // Full precision of one coefficient times one pixel
  typedef logic signed [2*`CONV_PIXEL_W-1:0] product_t;

  // Room for 16 products without overflow
  typedef logic signed [`CONV_SUM_W-1:0] sum_t;

  // Indexed [row][col], col 0 is the leftmost column
  typedef pixel_t [`CONV_KERNEL_DIM-1:0][`CONV_KERNEL_DIM-1:0] window_t;

endpackage

// File: common/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Image and kernel geometry
`define CONV_KERNEL_DIM   4
`define CONV_IMG_ROWS     8
`define CONV_IMG_COLS     16

// DRAM read bursts
`define CONV_BURST_LEN    8
`define CONV_DRAM_LATENCY 6

// Byte addresses in DRAM
`define CONV_KERNEL_BASE  0
`define CONV_IMG_BASE     16
`define CONV_OUT_BASE     4096

`define CONV_ADDR_W       32
`define CONV_PIXEL_W      8
`define CONV_SUM_W        20

`endif
